// File: hw/riscv_pkg.sv
package riscv_pkg;

  // rv32i major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    lui      = 7'b0110111,
    auipc    = 7'b0010111,
    jal      = 7'b1101111,
    jalr     = 7'b1100111,
    branch   = 7'b1100011,
    load     = 7'b0000011,
    store    = 7'b0100011,
    op_imm   = 7'b0010011,
    op       = 7'b0110011,
    misc_mem = 7'b0001111,
    system   = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    add, sub, sll, slt, sltu, xor_op, srl, sra, or_op, and_op, pass_b
  } alu_op_t;

  // encoded like funct3 of the branch instructions
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } cmp_op_t;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    byte_sz = 2'b00,
    half_sz = 2'b01,
    word_sz = 2'b10
  } mem_size_t;

  typedef enum logic [2:0] {
    fetch, decode, execute, mem_wait, writeback, trapped
  } cpu_state_t;

  typedef enum logic [1:0] {
    trap_mem, trap_illegal, trap_env, trap_misaligned
  } trap_code_t;

  localparam logic [1:0] axi_resp_okay   = 2'b00;
  localparam logic [1:0] axi_resp_exokay = 2'b01;
  localparam logic [2:0] inst_prot = 3'b101; // privileged, secure, instruction
  localparam logic [2:0] data_prot = 3'b000; // unprivileged, secure, data

endpackage

// File: hw/instr_decoder.sv
module instr_decoder import riscv_pkg::*; (
  input  var [31:0]   instr,
  output var [4:0]    rd,
  output var [4:0]    rs1,
  output var [4:0]    rs2,
  output var [31:0]   imm,
  output var opcode_t opcode,
  output var alu_op_t alu_op,
  output var cmp_op_t cmp_op,
  output var          use_imm,
  output var          reg_write,
  output var          load_unsigned,
  output var mem_size_t mem_size,
  output var          is_env,
  output var          illegal
);
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_t     arith_op;

  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign opcode = opcode_t'(instr[6:0]);

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct3 to alu op for op and op_imm, funct7[5] picks sub / sra
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == op && funct7[5]) ? sub : add;
      3'b001:  arith_op = sll;
      3'b010:  arith_op = slt;
      3'b011:  arith_op = sltu;
      3'b100:  arith_op = xor_op;
      3'b101:  arith_op = funct7[5] ? sra : srl;
      3'b110:  arith_op = or_op;
      default: arith_op = and_op;
    endcase
  end

  always_comb begin
    imm           = 32'b0;
    alu_op        = add;
    cmp_op        = cmp_op_t'(funct3);
    use_imm       = 1'b0;
    reg_write     = 1'b0;
    load_unsigned = funct3[2];
    mem_size      = mem_size_t'(funct3[1:0]);
    is_env        = 1'b0;
    illegal       = 1'b0;
    case (instr[6:0])
      lui: begin
        imm = imm_u; alu_op = pass_b; use_imm = 1'b1; reg_write = 1'b1;
      end
      auipc: begin
        imm = imm_u; use_imm = 1'b1; reg_write = 1'b1; // pc + imm, core selects pc
      end
      jal: begin
        imm = imm_j; reg_write = 1'b1;
      end
      jalr: begin
        imm = imm_i; use_imm = 1'b1; reg_write = 1'b1;
        illegal = funct3 != 3'b000;
      end
      branch: begin
        imm = imm_b;
        illegal = funct3[2:1] == 2'b01; // 010 and 011 unused
      end
      load: begin
        imm = imm_i; use_imm = 1'b1; reg_write = 1'b1;
        illegal = funct3[1:0] == 2'b11 || funct3 == 3'b110;
      end
      store: begin
        imm = imm_s; use_imm = 1'b1;
        illegal = funct3[2] || funct3[1:0] == 2'b11;
      end
      op_imm: begin
        imm = imm_i; alu_op = arith_op; use_imm = 1'b1; reg_write = 1'b1;
        if (funct3 == 3'b001) illegal = funct7 != 7'h00;
        if (funct3 == 3'b101) illegal = funct7 != 7'h00 && funct7 != 7'h20;
      end
      op: begin
        alu_op = arith_op; reg_write = 1'b1;
        illegal = !(funct7 == 7'h00 ||
                    (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      misc_mem: illegal = funct3 != 3'b000; // fence only, runs as nop
      system: begin
        // only ecall and ebreak, no csrs
        is_env  = instr == 32'h0000_0073 || instr == 32'h0010_0073;
        illegal = !is_env;
      end
      default: illegal = 1'b1;
    endcase
  end
endmodule

// File: hw/reg_file.sv
module reg_file (
  input  var        clk,
  input  var        reset,
  input  var        we,
  input  var [4:0]  waddr,
  input  var [4:0]  raddr1,
  input  var [4:0]  raddr2,
  input  var [31:0] wdata,
  output var [31:0] rdata1,
  output var [31:0] rdata2
);
  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (!reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'b0;
      end
    end else if (we && waddr != 5'd0) begin // x0 stays zero
      regs[waddr] <= wdata;
    end
  end

  // async read, same cycle as address
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

// File: hw/alu.sv
module alu import riscv_pkg::*; (
  input  var alu_op_t op,
  input  var cmp_op_t cmp,
  input  var [31:0]   a,
  input  var [31:0]   b,
  output var [31:0]   result,
  output var          taken
);
  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      add:     result = a + b;
      sub:     result = a - b;
      sll:     result = a << shamt;
      slt:     result = {31'b0, $signed(a) < $signed(b)};
      sltu:    result = {31'b0, a < b};
      xor_op:  result = a ^ b;
      srl:     result = a >> shamt;
      sra:     result = $signed(a) >>> shamt;
      or_op:   result = a | b;
      and_op:  result = a & b;
      pass_b:  result = b; // lui
      default: result = a + b;
    endcase
  end

  // branch condition on rs1 / rs2
  always_comb begin
    case (cmp)
      beq:     taken = a == b;
      bne:     taken = a != b;
      blt:     taken = $signed(a) < $signed(b);
      bge:     taken = $signed(a) >= $signed(b);
      bltu:    taken = a < b;
      bgeu:    taken = a >= b;
      default: taken = 1'b0;
    endcase
  end
endmodule

// File: hw/axi_lite_master.sv
module axi_lite_master import riscv_pkg::*; (
  input  var        clk,
  input  var        reset,

  // request from the core
  input  var        req_valid,
  input  var        req_write,
  input  var [31:0] req_addr,
  input  var [2:0]  req_prot,
  input  var [31:0] req_wdata,
  input  var [3:0]  req_wstrb,
  output var        req_done,
  output var        rsp_err,
  output var [31:0] rsp_data,

  // axi4-lite master
  output var        awvalid,
  input  var        awready,
  output var [31:0] awaddress,
  output var [2:0]  awprot,
  output var        wvalid,
  input  var        wready,
  output var [31:0] wdata,
  output var [3:0]  wstrb,
  input  var        bvalid,
  output var        bready,
  input  var [1:0]  bresp,
  output var        arvalid,
  input  var        arready,
  output var [31:0] araddress,
  output var [2:0]  arprot,
  input  var        rvalid,
  output var        rready,
  input  var [31:0] rdata,
  input  var [1:0]  rresp
);
  typedef enum logic [1:0] {m_idle, m_read, m_write, m_resp} bus_state_t;

  bus_state_t state;
  logic       start;

  function automatic logic resp_bad(input logic [1:0] resp);
    return !(resp == axi_resp_okay || resp == axi_resp_exokay);
  endfunction

  // m_resp blocks a restart while the core still holds req_valid
  assign start    = state == m_idle && req_valid;
  assign req_done = state == m_resp;

  always_ff @(posedge clk) begin
    if (!reset) begin
      state   <= m_idle;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
    end else begin
      case (state)
        m_idle: if (req_valid) begin
          if (req_write) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            bready  <= 1'b1;
            state   <= m_write;
          end else begin
            arvalid <= 1'b1;
            rready  <= 1'b1;
            state   <= m_read;
          end
        end
        m_read: begin
          if (arready) arvalid <= 1'b0;
          if (rvalid && rready) begin
            rready <= 1'b0;
            state  <= m_resp;
          end
        end
        m_write: begin
          // aw and w finish on their own, each valid is its pending flag
          if (awready) awvalid <= 1'b0;
          if (wready) wvalid <= 1'b0;
          if (bvalid && bready) begin
            bready <= 1'b0;
            state  <= m_resp;
          end
        end
        default: state <= m_idle; // m_resp, req_done high for this cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      araddress <= req_addr;
      arprot    <= req_prot;
      awaddress <= req_addr;
      awprot    <= req_prot;
      wdata     <= req_wdata;
      wstrb     <= req_wstrb;
    end
    if (state == m_read && rvalid && rready) begin
      rsp_data <= rdata;
      rsp_err  <= resp_bad(rresp);
    end
    if (state == m_write && bvalid && bready) rsp_err <= resp_bad(bresp);
  end
endmodule

// File: hw/riscv.sv
module riscv import riscv_pkg::*; #(
  parameter logic [31:0] reset_vector = 32'h0
) (
  input  var        clk,
  input  var        reset,
  output var        awvalid,
  input  var        awready,
  output var [31:0] awaddress,
  output var [2:0]  awprot,
  output var        wvalid,
  input  var        wready,
  output var [31:0] wdata,
  output var [3:0]  wstrb,
  input  var        bvalid,
  output var        bready,
  input  var [1:0]  bresp,
  output var        arvalid,
  input  var        arready,
  output var [31:0] araddress,
  output var [2:0]  arprot,
  input  var        rvalid,
  output var        rready,
  input  var [31:0] rdata,
  input  var [1:0]  rresp,
  output var        trap,
  output var trap_code_t trap_code
);
  cpu_state_t  state;
  logic [31:0] pc, ir, npc;
  logic [31:0] op_a, op_b, st_data, mem_addr, wb_data;

  logic [4:0]  rd, rs1, rs2;
  logic [31:0] imm, rs1_val, rs2_val, alu_res;
  opcode_t     opcode;
  alu_op_t     alu_op;
  cmp_op_t     cmp_op;
  mem_size_t   mem_size;
  logic        use_imm, reg_write, load_unsigned, is_env, illegal, taken;

  logic        req_valid, req_write, req_done, rsp_err;
  logic [31:0] req_addr, req_wdata, rsp_data;
  logic [2:0]  req_prot;
  logic [3:0]  req_wstrb;

  logic [31:0] link, br_target, target, load_lanes, load_val;
  logic [4:0]  byte_shift;
  logic        jump, is_mem, target_bad, addr_bad;

  instr_decoder decoder_i (
    .instr(ir), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .opcode(opcode),
    .alu_op(alu_op), .cmp_op(cmp_op), .use_imm(use_imm), .reg_write(reg_write),
    .load_unsigned(load_unsigned), .mem_size(mem_size), .is_env(is_env), .illegal(illegal)
  );

  reg_file reg_file_i (
    .clk(clk), .reset(reset), .we(state == writeback && reg_write), .waddr(rd),
    .raddr1(rs1), .raddr2(rs2), .wdata(wb_data), .rdata1(rs1_val), .rdata2(rs2_val)
  );

  alu alu_i (.op(alu_op), .cmp(cmp_op), .a(op_a), .b(op_b), .result(alu_res), .taken(taken));

  axi_lite_master bus_i (
    .clk(clk), .reset(reset), .req_valid(req_valid), .req_write(req_write),
    .req_addr(req_addr), .req_prot(req_prot), .req_wdata(req_wdata), .req_wstrb(req_wstrb),
    .req_done(req_done), .rsp_err(rsp_err), .rsp_data(rsp_data),
    .awvalid(awvalid), .awready(awready), .awaddress(awaddress), .awprot(awprot),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddress(araddress), .arprot(arprot),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
  );

  // next pc and effective address checks, valid in execute
  assign link      = pc + 32'd4;
  assign br_target = pc + imm;
  assign is_mem    = opcode == load || opcode == store;

  always_comb begin
    jump   = 1'b0;
    target = link;
    case (opcode)
      jal:     begin jump = 1'b1; target = br_target; end
      jalr:    begin jump = 1'b1; target = {alu_res[31:1], 1'b0}; end
      branch:  begin jump = taken; target = taken ? br_target : link; end
      default: ;
    endcase
  end

  assign target_bad = jump && target[1:0] != 2'b00;
  assign addr_bad   = (mem_size == half_sz && alu_res[0]) ||
                      (mem_size == word_sz && alu_res[1:0] != 2'b00);

  // one request at a time, fetch or data
  assign req_valid = state == fetch || state == mem_wait;
  assign req_write = state == mem_wait && opcode == store;
  assign req_addr  = state == fetch ? pc : mem_addr;
  assign req_prot  = state == fetch ? inst_prot : data_prot;

  // byte lanes from the low address bits
  assign byte_shift = {mem_addr[1:0], 3'b000};
  assign req_wdata  = st_data << byte_shift;
  assign load_lanes = rsp_data >> byte_shift;

  always_comb begin
    case (mem_size)
      byte_sz: req_wstrb = 4'b0001 << mem_addr[1:0];
      half_sz: req_wstrb = 4'b0011 << mem_addr[1:0];
      default: req_wstrb = 4'b1111;
    endcase
    case (mem_size)
      byte_sz: load_val = {{24{load_lanes[7] & !load_unsigned}}, load_lanes[7:0]};
      half_sz: load_val = {{16{load_lanes[15] & !load_unsigned}}, load_lanes[15:0]};
      default: load_val = load_lanes;
    endcase
  end

  assign trap = state == trapped;

  always_ff @(posedge clk) begin
    if (!reset) begin
      state     <= fetch;
      pc        <= reset_vector;
      trap_code <= trap_mem;
    end else begin
      case (state)
        fetch: if (req_done) begin
          state <= rsp_err ? trapped : decode;
          trap_code <= trap_mem;
        end
        decode: begin
          state <= (illegal || is_env) ? trapped : execute;
          trap_code <= illegal ? trap_illegal : trap_env;
        end
        execute: begin
          trap_code <= trap_misaligned;
          if (target_bad || (is_mem && addr_bad)) state <= trapped;
          else state <= is_mem ? mem_wait : writeback;
        end
        mem_wait: if (req_done) begin
          state <= rsp_err ? trapped : writeback;
          trap_code <= trap_mem;
        end
        writeback: begin
          pc    <= npc;
          state <= fetch;
        end
        default: state <= trapped; // stays here until reset
      endcase
    end
  end

  // datapath registers
  always_ff @(posedge clk) begin
    case (state)
      fetch: if (req_done) ir <= rsp_data;
      decode: begin
        op_a    <= opcode == auipc ? pc : rs1_val;
        op_b    <= use_imm ? imm : rs2_val;
        st_data <= rs2_val;
      end
      execute: begin
        mem_addr <= alu_res;
        npc      <= target;
        wb_data  <= (opcode == jal || opcode == jalr) ? link : alu_res;
      end
      mem_wait: if (req_done) wb_data <= load_val; // store leaves it unused
      default: ;
    endcase
  end
endmodule

// File: verification/tb_clock.sv
module tb_clock #(
  parameter int period = 100
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ns;

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk; // 50 ns high, 50 ns low
  end
endmodule

// File: verification/riscv_properties.sv
module riscv_properties import riscv_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       arvalid,
  input logic       arready,
  input logic       awvalid,
  input logic       awready,
  input logic       wvalid,
  input logic       wready,
  input logic       trap,
  input cpu_state_t state
);
  timeunit 1ns;
  timeprecision 1ns;

  // a valid stays up until its ready
  ar_held: assert property (@(posedge clk) disable iff (!reset) arvalid && !arready |=> arvalid)
    else $error("arvalid dropped before arready");
  aw_held: assert property (@(posedge clk) disable iff (!reset) awvalid && !awready |=> awvalid)
    else $error("awvalid dropped before awready");
  w_held: assert property (@(posedge clk) disable iff (!reset) wvalid && !wready |=> wvalid)
    else $error("wvalid dropped before wready");

  // trap is sticky until the next reset
  trap_sticky: assert property (@(posedge clk) disable iff (!reset) trap |=> trap)
    else $error("trap fell without a reset");

  // bus requests only while the core waits on fetch or data
  req_source: assert property (@(posedge clk) disable iff (!reset)
    arvalid || awvalid |-> state == fetch || state == mem_wait)
    else $error("bus request outside fetch and mem_wait");

  // a trapped core issues no requests
  trap_quiet: assert property (@(posedge clk) disable iff (!reset) trap |-> !arvalid && !awvalid)
    else $error("request issued while trapped");
endmodule

// File: verification/riscv_tb.sv
module riscv_tb import riscv_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ns;

  localparam int n_runs    = 10;   // alu, branch, mem, four traps, three with back-pressure
  localparam int run_limit = 4000; // cycles per program

  logic        clk, reset;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready, trap;
  logic [31:0] awaddress, wdata, araddress, rdata;
  logic [3:0]  wstrb;
  logic [2:0]  awprot, arprot;
  logic [1:0]  bresp, rresp;
  trap_code_t  trap_code;

  logic [31:0] mem [1024]; // 4 KiB, word addressed by addr[11:2]
  logic [31:0] exp_q [$];
  logic [31:0] wlog_addr [$], wlog_data [$];
  logic [3:0]  wlog_strb [$];
  int          pc_idx, checks, value_errors, other_errors, ar_count, aw_count;
  integer      seed;
  bit          backpressure;

  // slave side state
  logic        rd_pend, aw_done, w_done;
  logic [31:0] rd_addr, wr_addr, wr_data;
  logic [3:0]  wr_strb;

  tb_clock #(.period(100)) clock_i (.clk(clk));

  riscv #(.reset_vector(32'h0)) riscv_i (
    .clk(clk), .reset(reset),
    .awvalid(awvalid), .awready(awready), .awaddress(awaddress), .awprot(awprot),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddress(araddress), .arprot(arprot),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
    .trap(trap), .trap_code(trap_code)
  );

  bind riscv riscv_properties props_i (
    .clk(clk), .reset(reset), .arvalid(arvalid), .arready(arready),
    .awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
    .trap(trap), .state(state)
  );

  task automatic value_err(input string msg);
    $display("ERR %0t: %s", $time, msg);
    value_errors++;
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) value_err($sformatf("%s got %h expected %h", what, got, want));
  endtask

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
  endfunction

  function automatic bit ready_roll();
    if (!backpressure) return 1'b1;
    return ($random(seed) & 3) != 0; // ready about three times in four
  endfunction

  // rv32i encodings
  function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(int off, int rs2, int rs1, int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(int imm20, int rd, logic [6:0] opc);
    return {imm20[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_j(int off, int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] addi(int rd, int rs1, int imm);
    return enc_i(imm, rs1, 0, rd, 7'b0010011);
  endfunction

  task automatic emit(input logic [31:0] w);
    mem[pc_idx] = w;
    pc_idx++;
  endtask

  // store x3 to the next result slot and remember the expected value
  task automatic record(input logic [31:0] want);
    emit(enc_s(exp_q.size() * 4, 3, 31, 2));
    exp_q.push_back(want);
  endtask

  task automatic start_program();
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < 1024; i++) mem[i] = fill_word(i * 4);
    pc_idx = 0;
    exp_q.delete();
    wlog_addr.delete();
    wlog_data.delete();
    wlog_strb.delete();
    emit(addi(31, 0, 12'h200)); // x31 points at the result area
  endtask

  task automatic run_program(input string name, input trap_code_t want);
    int cycles;
    int ar0;
    int aw0;
    cycles = 0;
    repeat (10) @(negedge clk);
    reset = 1'b1;
    while (!trap && cycles < run_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!trap) begin
      $display("program %s did not reach a trap within %0d cycles", name, run_limit);
      other_errors++;
    end else begin
      check_eq({name, " trap_code"}, 32'(trap_code), 32'(want));
      ar0 = ar_count;
      aw0 = aw_count;
      repeat (20) @(negedge clk);
      if (ar_count != ar0 || aw_count != aw0) begin
        $display("program %s issued bus requests after its trap", name);
        other_errors++;
      end
    end
    for (int k = 0; k < exp_q.size(); k++)
      check_eq($sformatf("%s result %0d", name, k), mem[128 + k], exp_q[k]);
  endtask

  task automatic check_write(input logic [31:0] addr, input logic [3:0] strb,
                             input logic [31:0] mask, input logic [31:0] lanes);
    int found;
    found = -1;
    foreach (wlog_addr[i]) if (wlog_addr[i] == addr) found = i;
    if (found < 0) begin
      $display("no write to address %h was seen on the bus", addr);
      other_errors++;
    end else begin
      check_eq($sformatf("wstrb at %h", addr), 32'(wlog_strb[found]), 32'(strb));
      check_eq($sformatf("w lanes at %h", addr), wlog_data[found] & mask, lanes);
    end
  endtask

  task automatic test_alu();
    logic [31:0] a, b;
    a = 32'hffff_fb2e; // -1234
    b = 32'h1234_5678;
    start_program();
    emit(addi(1, 0, -1234));
    emit(enc_u(20'h12345, 2, 7'b0110111));
    emit(addi(2, 2, 12'h678));
    emit(enc_r(0, 2, 1, 0, 3));
    record(a + b);
    emit(enc_r(7'h20, 2, 1, 0, 3));
    record(a - b);
    emit(enc_r(0, 1, 2, 1, 3));
    record(b << a[4:0]);
    emit(enc_r(0, 2, 1, 2, 3));
    record(($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    emit(enc_r(0, 2, 1, 3, 3));
    record((a < b) ? 32'd1 : 32'd0);
    emit(enc_r(0, 2, 1, 4, 3));
    record(a ^ b);
    emit(enc_r(0, 2, 1, 5, 3));
    record(a >> b[4:0]);
    emit(enc_r(7'h20, 2, 1, 5, 3));
    record($signed(a) >>> b[4:0]);
    emit(enc_r(0, 2, 1, 6, 3));
    record(a | b);
    emit(enc_r(0, 2, 1, 7, 3));
    record(a & b);
    emit(enc_i(-1000, 1, 2, 3, 7'b0010011));
    record(($signed(a) < -1000) ? 32'd1 : 32'd0);
    emit(enc_i(5, 1, 3, 3, 7'b0010011));
    record((a < 32'd5) ? 32'd1 : 32'd0);
    emit(enc_i(12'h0f0, 2, 4, 3, 7'b0010011));
    record(b ^ 32'h0f0);
    emit(enc_i(12'h123, 1, 6, 3, 7'b0010011));
    record(a | 32'h123);
    emit(enc_i(-16, 2, 7, 3, 7'b0010011));
    record(b & 32'hffff_fff0);
    emit(enc_i(7, 2, 1, 3, 7'b0010011));
    record(b << 7);
    emit(enc_i(3, 1, 5, 3, 7'b0010011));
    record(a >> 3);
    emit(enc_i(12'h403, 1, 5, 3, 7'b0010011));
    record($signed(a) >>> 3);
    emit(addi(3, 1, 2047));
    record(a + 32'd2047);
    emit(enc_u(20'hfedcb, 3, 7'b0110111));
    record(32'hfedc_b000);
    emit(enc_u(20'h00010, 3, 7'b0010111));
    record(32'((pc_idx - 1) * 4) + 32'h1_0000);
    emit(32'h0010_0073); // ebreak
    run_program("alu", trap_env);
  endtask

  task automatic do_branch(input int f3, input int ra, input int rb,
                           input logic [31:0] va, input logic [31:0] vb);
    bit taken;
    case (f3)
      0: taken = va == vb;
      1: taken = va != vb;
      4: taken = $signed(va) < $signed(vb);
      5: taken = $signed(va) >= $signed(vb);
      6: taken = va < vb;
      default: taken = va >= vb;
    endcase
    emit(addi(3, 0, 1));
    emit(enc_b(8, rb, ra, f3)); // skips the next instruction when taken
    emit(addi(3, 0, 2));
    record(taken ? 32'd1 : 32'd2);
  endtask

  task automatic test_branches();
    logic [31:0] m5, p;
    m5 = 32'hffff_fffb;
    start_program();
    emit(addi(1, 0, -5));
    emit(addi(2, 0, 3));
    emit(addi(4, 0, -5));
    do_branch(0, 1, 4, m5, m5);
    do_branch(0, 1, 2, m5, 3);
    do_branch(1, 1, 2, m5, 3);
    do_branch(1, 1, 4, m5, m5);
    do_branch(4, 1, 2, m5, 3);
    do_branch(4, 2, 1, 3, m5);
    do_branch(5, 2, 1, 3, m5);
    do_branch(5, 1, 2, m5, 3);
    do_branch(6, 2, 1, 3, m5);
    do_branch(6, 1, 2, m5, 3);
    do_branch(7, 1, 2, m5, 3);
    do_branch(7, 2, 1, 3, m5);
    // backward loop, five rounds of +3
    emit(addi(7, 0, 0));
    emit(addi(8, 0, 5));
    emit(addi(7, 7, 3));
    emit(addi(8, 8, -1));
    emit(enc_b(-8, 0, 8, 1));
    emit(addi(3, 7, 0));
    record(32'd15);
    emit(addi(3, 0, 12'h55));
    p = 32'(pc_idx * 4);
    emit(enc_j(12, 9));
    emit(addi(3, 0, 7));
    emit(addi(3, 0, 7));
    record(32'h55);
    emit(addi(3, 9, 0));
    record(p + 4); // jal link
    emit(addi(3, 0, 12'h66));
    p = 32'(pc_idx * 4);
    emit(enc_u(0, 10, 7'b0010111));
    emit(enc_i(17, 10, 0, 11, 7'b1100111)); // bit 0 of the target is dropped
    emit(addi(3, 0, 9));
    emit(addi(3, 0, 9));
    record(32'h66);
    emit(addi(3, 11, 0));
    record(p + 8); // jalr link
    emit(32'h0010_0073);
    run_program("branch", trap_env);
  endtask

  task automatic test_mem();
    logic [31:0] f, f304, f308;
    f = fill_word(32'h320);
    f304 = fill_word(32'h304);
    f308 = fill_word(32'h308);
    start_program();
    emit(addi(1, 0, -1234));
    emit(enc_u(20'h12345, 2, 7'b0110111));
    emit(addi(2, 2, 12'h678));
    emit(enc_s(12'h100, 2, 31, 2)); // sw at 0x300
    emit(enc_s(12'h105, 2, 31, 0)); // sb at 0x305
    emit(enc_s(12'h10a, 2, 31, 1)); // sh at 0x30a
    emit(enc_s(12'h110, 1, 31, 2));
    emit(enc_i(12'h100, 31, 2, 3, 7'b0000011));
    record(32'h1234_5678);
    emit(enc_i(12'h105, 31, 4, 3, 7'b0000011));
    record(32'h78);
    emit(enc_i(12'h10a, 31, 5, 3, 7'b0000011));
    record(32'h5678);
    emit(enc_i(12'h110, 31, 0, 3, 7'b0000011));
    record(32'h2e);
    emit(enc_i(12'h111, 31, 0, 3, 7'b0000011));
    record(32'hffff_fffb);
    emit(enc_i(12'h111, 31, 4, 3, 7'b0000011));
    record(32'hfb);
    emit(enc_i(12'h112, 31, 1, 3, 7'b0000011));
    record(32'hffff_ffff);
    emit(enc_i(12'h112, 31, 5, 3, 7'b0000011));
    record(32'h0000_ffff);
    emit(enc_i(12'h110, 31, 1, 3, 7'b0000011));
    record(32'hffff_fb2e);
    emit(enc_i(12'h110, 31, 5, 3, 7'b0000011));
    record(32'h0000_fb2e);
    emit(enc_i(12'h120, 31, 2, 3, 7'b0000011));
    record(f);
    emit(enc_i(12'h121, 31, 0, 3, 7'b0000011));
    record({{24{f[15]}}, f[15:8]});
    emit(32'h0010_0073);
    run_program("mem", trap_env);
    check_eq("word at 0x304", mem[32'h304 >> 2], {f304[31:16], 8'h78, f304[7:0]});
    check_eq("word at 0x308", mem[32'h308 >> 2], {16'h5678, f308[15:0]});
    check_write(32'h300, 4'b1111, 32'hffff_ffff, 32'h1234_5678);
    check_write(32'h305, 4'b0010, 32'h0000_ff00, 32'h0000_7800);
    check_write(32'h30a, 4'b1100, 32'hffff_0000, 32'h5678_0000);
  endtask

  task automatic test_traps();
    start_program();
    emit(32'hffff_ffff); // no such opcode
    run_program("illegal", trap_illegal);
    start_program();
    emit(addi(1, 0, 12'h302));
    emit(enc_i(0, 1, 2, 3, 7'b0000011)); // lw from 0x302
    run_program("misaligned", trap_misaligned);
    start_program();
    emit(enc_u(20'h80000, 1, 7'b0110111));
    emit(enc_i(0, 1, 2, 3, 7'b0000011)); // error range
    run_program("slave error", trap_mem);
    start_program();
    emit(32'h0000_0073); // ecall
    run_program("ecall", trap_env);
  endtask

  // axi4-lite slave, all outputs change on the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      arready = 1'b0;
      rvalid  = 1'b0;
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
      rd_pend = 1'b0;
      aw_done = 1'b0;
      w_done  = 1'b0;
    end else begin
      if (arready) begin // beat taken on the last rising edge
        arready = 1'b0;
        rd_pend = 1'b1;
      end else if (arvalid && !rd_pend && !rvalid && ready_roll()) begin
        arready = 1'b1;
        rd_addr = araddress;
        ar_count++;
        check_eq("arprot", 32'(arprot), araddress < 32'h200 ? 32'b101 : 32'b000);
      end
      if (rvalid) rvalid = 1'b0;
      else if (rd_pend && ready_roll()) begin
        rvalid  = 1'b1;
        rd_pend = 1'b0;
        rresp   = rd_addr[31] ? 2'b10 : 2'b00; // upper half answers slverr
        rdata   = rd_addr[31] ? 32'hdead_beef : mem[rd_addr[11:2]];
        if (!rready) begin // beat only lands if the master is ready
          $display("rready was low while the slave offered read data");
          other_errors++;
        end
      end
      if (awready) begin
        awready = 1'b0;
        aw_done = 1'b1;
      end else if (awvalid && !aw_done && !bvalid && ready_roll()) begin
        awready = 1'b1;
        wr_addr = awaddress;
        aw_count++;
        check_eq("awprot", 32'(awprot), 32'b000);
      end
      if (wready) begin
        wready = 1'b0;
        w_done = 1'b1;
      end else if (wvalid && !w_done && !bvalid && ready_roll()) begin
        wready  = 1'b1;
        wr_data = wdata;
        wr_strb = wstrb;
      end
      if (bvalid) bvalid = 1'b0;
      else if (aw_done && w_done && ready_roll()) begin
        if (!wr_addr[31]) begin
          for (int b = 0; b < 4; b++)
            if (wr_strb[b]) mem[wr_addr[11:2]][8 * b +: 8] = wr_data[8 * b +: 8];
        end
        wlog_addr.push_back(wr_addr);
        wlog_data.push_back(wr_data);
        wlog_strb.push_back(wr_strb);
        bresp   = wr_addr[31] ? 2'b10 : 2'b00;
        bvalid  = 1'b1;
        aw_done = 1'b0;
        w_done  = 1'b0;
        if (!bready) begin
          $display("bready was low while the slave offered a write response");
          other_errors++;
        end
      end
    end
  end

  initial begin
    #(longint'(n_runs) * run_limit * 100);
    $display("watchdog expired before the tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    reset = 1'b0;
    arready = 1'b0;
    rvalid = 1'b0;
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    rdata = 32'b0;
    rresp = 2'b00;
    bresp = 2'b00;
    seed = 7;
    backpressure = 1'b0;
    checks = 0;
    value_errors = 0;
    other_errors = 0;
    ar_count = 0;
    aw_count = 0;
    test_alu();
    test_branches();
    test_mem();
    test_traps();
    backpressure = 1'b1; // same programs with random ready gaps
    test_alu();
    test_branches();
    test_mem();
    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errors,
             other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end
endmodule

// File: compile.f
hw/riscv_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/axi_lite_master.sv
hw/riscv.sv
verification/tb_clock.sv
verification/riscv_properties.sv
verification/riscv_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module riscv_tb \
  -Mdir obj_dir -o riscv_sim > build.log 2>&1 \
  && ./obj_dir/riscv_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || grep -q "SIMULATION PASSED" sim.log
